// File: common/mem_sys_pkg.sv
// Memory subsystem shared definitions
// Message format, opcodes, address map and the DRAM init pattern rule

`default_nettype none

package mem_sys_pkg;

  typedef enum logic
  {
    MEM_RD = 1'b0,
    MEM_WR = 1'b1
  } mem_op_e;

  typedef logic [31:0] mem_addr_t;
  typedef logic [31:0] mem_data_t;

  // Shared by commands and responses
  typedef struct packed
  {
    mem_op_e   op;
    mem_addr_t addr;
    mem_data_t data;
  } mem_msg_s;

  // Everything at or above this belongs to the DRAM
  localparam mem_addr_t DRAM_BASE = 32'h8000_0000;

  // Host MMIO registers
  localparam mem_addr_t MMIO_FINISH_ADDR  = 32'h0000_0000;
  localparam mem_addr_t MMIO_SCRATCH_ADDR = 32'h0000_0004;
  localparam mem_addr_t MMIO_COUNT_ADDR   = 32'h0000_0008;

  localparam mem_data_t INIT_SEED = 32'hc0de_0000;

  // Init pattern for DRAM word idx
  function automatic mem_data_t mem_init_word(input int unsigned idx);
    return INIT_SEED ^ mem_data_t'(idx);
  endfunction

endpackage

`default_nettype wire

// File: common/mem_msg_if.sv
// Memory message channel
// Valid/ready handshake carrying one mem_msg_s per transfer

`timescale 1ns/1ns
`default_nettype none

interface mem_msg_if;
  import mem_sys_pkg::*;

  logic     v;
  logic     ready;
  mem_msg_s msg;

  // Producer holds msg stable while v is high
  modport prod
  (
    output v,
    output msg,
    input  ready
  );

  modport cons
  (
    input  v,
    input  msg,
    output ready
  );

endinterface

`default_nettype wire

// File: logic/mem_cfg_loader.sv
// Configuration loader
// Writes the init pattern into the first DRAM words after reset, then reports done

`timescale 1ns/1ns
`default_nettype none

module mem_cfg_loader
#(
  parameter int init_words_p = 8
)
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  mem_msg_if.prod  cmd,
  mem_msg_if.cons  resp,
  output logic     done_o
);
  import mem_sys_pkg::*;

  localparam int idx_w_lp = $clog2(init_words_p + 1);

  typedef enum logic [1:0]
  {
    LD_ISSUE,
    LD_WAIT,
    LD_DONE
  } ld_state_e;

  ld_state_e           state_r;
  logic [idx_w_lp-1:0] idx_r;
  logic                last_word;

  assign last_word = (idx_r == idx_w_lp'(init_words_p - 1));

  assign cmd.v        = (state_r == LD_ISSUE);
  assign cmd.msg.op   = MEM_WR;
  assign cmd.msg.addr = DRAM_BASE + (mem_addr_t'(idx_r) << 2);
  assign cmd.msg.data = mem_init_word(idx_r);

  assign resp.ready = (state_r == LD_WAIT);
  assign done_o     = (state_r == LD_DONE);

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_r <= LD_ISSUE;
      idx_r   <= '0;
    end
    else
    begin
      case (state_r)
        LD_ISSUE:
          if (cmd.ready)
            state_r <= LD_WAIT;
        LD_WAIT:
          if (resp.v)
          begin
            // One word at a time
            if (last_word)
              state_r <= LD_DONE;
            else
            begin
              idx_r   <= idx_r + 1'b1;
              state_r <= LD_ISSUE;
            end
          end
        default:
          state_r <= LD_DONE;
      endcase
    end
  end

  // No new write while the previous one still has a response coming back
  a_no_cmd_while_waiting: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cmd.v |-> !resp.v);

endmodule

`default_nettype wire

// File: logic/mem_cmd_router.sv
// Command router
// Picks the loader or external source, steers commands by address and
// returns the merged target responses, with one request in flight

`timescale 1ns/1ns
`default_nettype none

module mem_cmd_router
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     init_done_i,
  mem_msg_if.cons  ldr_cmd,
  mem_msg_if.cons  ext_cmd,
  mem_msg_if.prod  dram_cmd,
  mem_msg_if.prod  mmio_cmd,
  mem_msg_if.cons  dram_resp,
  mem_msg_if.cons  mmio_resp,
  mem_msg_if.prod  ldr_resp,
  mem_msg_if.prod  ext_resp
);
  import mem_sys_pkg::*;

  logic     outstanding_r;
  logic     src_v;
  mem_msg_s src_msg;
  logic     to_mmio;
  logic     tgt_ready;
  logic     accept;
  logic     rsp_v;
  logic     rsp_ready;
  mem_msg_s rsp_msg;
  logic     deliver;

  // Loader owns the port until init completes
  assign src_v   = init_done_i ? ext_cmd.v   : ldr_cmd.v;
  assign src_msg = init_done_i ? ext_cmd.msg : ldr_cmd.msg;

  assign to_mmio = (src_msg.addr < DRAM_BASE);

  assign dram_cmd.v   = src_v & ~to_mmio & ~outstanding_r;
  assign dram_cmd.msg = src_msg;
  assign mmio_cmd.v   = src_v & to_mmio & ~outstanding_r;
  assign mmio_cmd.msg = src_msg;

  assign tgt_ready     = ~outstanding_r & (to_mmio ? mmio_cmd.ready : dram_cmd.ready);
  assign ldr_cmd.ready = ~init_done_i & tgt_ready;
  assign ext_cmd.ready = init_done_i & tgt_ready;

  assign accept = (dram_cmd.v & dram_cmd.ready) | (mmio_cmd.v & mmio_cmd.ready);

  // Response merge
  assign rsp_v   = dram_resp.v | mmio_resp.v;
  assign rsp_msg = mmio_resp.v ? mmio_resp.msg : dram_resp.msg;

  assign ldr_resp.v   = rsp_v & ~init_done_i;
  assign ldr_resp.msg = rsp_msg;
  assign ext_resp.v   = rsp_v & init_done_i;
  assign ext_resp.msg = rsp_msg;

  assign rsp_ready       = init_done_i ? ext_resp.ready : ldr_resp.ready;
  assign dram_resp.ready = rsp_ready;
  assign mmio_resp.ready = rsp_ready;

  assign deliver = rsp_v & rsp_ready;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      outstanding_r <= 1'b0;
    else if (accept)
      outstanding_r <= 1'b1;
    else if (deliver)
      outstanding_r <= 1'b0;
  end

  a_one_target_resp: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(dram_resp.v && mmio_resp.v));

  // A new command never overlaps a target response still pending
  a_no_cmd_in_flight: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    accept |-> !rsp_v);

endmodule

`default_nettype wire

// File: mem/mem_dram_model.sv
// DRAM model
// Word memory behind a valid/ready port with fixed or pseudo-random latency

`timescale 1ns/1ns
`default_nettype none

module mem_dram_model
#(
  parameter int mem_words_p          = 256,
  parameter int max_latency_p        = 6,
  parameter int use_random_latency_p = 1
)
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  mem_msg_if.cons  cmd,
  mem_msg_if.prod  resp
);
  import mem_sys_pkg::*;

  localparam int idx_w_lp = $clog2(mem_words_p);
  localparam int cnt_w_lp = $clog2(max_latency_p + 1);

  mem_data_t           mem_r [mem_words_p];
  mem_addr_t           word_off;
  logic [idx_w_lp-1:0] word_idx;
  logic                accept;

  logic [15:0]         lfsr_r;
  logic [15:0]         lat_rand;
  logic [cnt_w_lp-1:0] lat_m1;
  logic [cnt_w_lp-1:0] cnt_r;
  logic                pending_r;
  mem_msg_s            resp_msg_r;

  // Word offset from the base, wrapped to the capacity
  assign word_off = cmd.msg.addr - DRAM_BASE;
  assign word_idx = word_off[idx_w_lp+1:2];

  assign cmd.ready = ~pending_r;
  assign accept    = cmd.v & cmd.ready;

  assign lat_rand = lfsr_r % 16'(max_latency_p);
  assign lat_m1   = (use_random_latency_p != 0) ? cnt_w_lp'(lat_rand)
                                                : cnt_w_lp'(max_latency_p - 1);

  assign resp.v   = pending_r & (cnt_r == '0);
  assign resp.msg = resp_msg_r;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      lfsr_r <= 16'hace1;
    else
      lfsr_r <= {1'b0, lfsr_r[15:1]} ^ (lfsr_r[0] ? 16'hb400 : 16'h0000);
  end

  // Latency countdown, response held until cnt_r reaches zero
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      pending_r <= 1'b0;
      cnt_r     <= '0;
    end
    else if (accept)
    begin
      pending_r <= 1'b1;
      cnt_r     <= lat_m1;
    end
    else if (resp.v && resp.ready)
      pending_r <= 1'b0;
    else if (pending_r && cnt_r != '0)
      cnt_r <= cnt_r - 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      if (cmd.msg.op == MEM_WR)
        mem_r[word_idx] <= cmd.msg.data;
      resp_msg_r.op   <= cmd.msg.op;
      resp_msg_r.addr <= cmd.msg.addr;
      resp_msg_r.data <= (cmd.msg.op == MEM_WR) ? cmd.msg.data : mem_r[word_idx];
    end
  end

  a_resp_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (resp.v && !resp.ready) |=> (resp.v && $stable(resp.msg)));

endmodule

`default_nettype wire

// File: mem/mem_host_mmio.sv
// Host MMIO block
// Finish code, scratch word and a write counter, one-cycle response

`timescale 1ns/1ns
`default_nettype none

module mem_host_mmio
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  mem_msg_if.cons               cmd,
  mem_msg_if.prod               resp,
  output logic                  finish_v_o,
  output mem_sys_pkg::mem_data_t finish_code_o
);
  import mem_sys_pkg::*;

  logic      accept;
  logic      is_wr;
  logic      resp_v_r;
  mem_msg_s  resp_msg_r;
  mem_data_t rd_data;
  mem_data_t scratch_r;
  mem_data_t count_r;
  logic      finish_v_r;
  mem_data_t finish_code_r;

  assign cmd.ready = ~resp_v_r;
  assign accept    = cmd.v & cmd.ready;
  assign is_wr     = (cmd.msg.op == MEM_WR);

  always_comb
  begin
    case (cmd.msg.addr)
      MMIO_FINISH_ADDR:  rd_data = finish_code_r;
      MMIO_SCRATCH_ADDR: rd_data = scratch_r;
      MMIO_COUNT_ADDR:   rd_data = count_r;
      default:           rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      resp_v_r      <= 1'b0;
      scratch_r     <= '0;
      count_r       <= '0;
      finish_v_r    <= 1'b0;
      finish_code_r <= '0;
    end
    else
    begin
      if (accept)
        resp_v_r <= 1'b1;
      else if (resp.ready)
        resp_v_r <= 1'b0;

      if (accept && is_wr)
      begin
        // Counter itself is read-only
        count_r <= count_r + 1'b1;
        if (cmd.msg.addr == MMIO_SCRATCH_ADDR)
          scratch_r <= cmd.msg.data;
        if (cmd.msg.addr == MMIO_FINISH_ADDR)
        begin
          finish_v_r    <= 1'b1;
          finish_code_r <= cmd.msg.data;
        end
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      resp_msg_r <= '{op: cmd.msg.op, addr: cmd.msg.addr,
                      data: is_wr ? cmd.msg.data : rd_data};
  end

  assign resp.v        = resp_v_r;
  assign resp.msg      = resp_msg_r;
  assign finish_v_o    = finish_v_r;
  assign finish_code_o = finish_code_r;

endmodule

`default_nettype wire

// File: logic/mem_sys.sv
// Memory subsystem top
// Config loader, command router, DRAM model and host MMIO behind one port

`timescale 1ns/1ns
`default_nettype none

module mem_sys
#(
  parameter int init_words_p         = 8,
  parameter int mem_words_p          = 256,
  parameter int max_latency_p        = 6,
  parameter int use_random_latency_p = 1
)
(
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   cmd_v_i,
  output logic                   cmd_ready_o,
  input  mem_sys_pkg::mem_op_e   cmd_op_i,
  input  mem_sys_pkg::mem_addr_t cmd_addr_i,
  input  mem_sys_pkg::mem_data_t cmd_data_i,
  output logic                   resp_v_o,
  input  logic                   resp_ready_i,
  output mem_sys_pkg::mem_op_e   resp_op_o,
  output mem_sys_pkg::mem_addr_t resp_addr_o,
  output mem_sys_pkg::mem_data_t resp_data_o,
  output logic                   init_done_o,
  output logic                   finish_v_o,
  output mem_sys_pkg::mem_data_t finish_code_o
);

  mem_msg_if ldr_cmd_if ();
  mem_msg_if ldr_resp_if ();
  mem_msg_if ext_cmd_if ();
  mem_msg_if ext_resp_if ();
  mem_msg_if dram_cmd_if ();
  mem_msg_if dram_resp_if ();
  mem_msg_if mmio_cmd_if ();
  mem_msg_if mmio_resp_if ();

  logic init_done;

  // External port
  assign ext_cmd_if.v   = cmd_v_i;
  assign ext_cmd_if.msg = '{op: cmd_op_i, addr: cmd_addr_i, data: cmd_data_i};
  assign cmd_ready_o    = ext_cmd_if.ready;

  assign resp_v_o          = ext_resp_if.v;
  assign ext_resp_if.ready = resp_ready_i;
  assign resp_op_o         = ext_resp_if.msg.op;
  assign resp_addr_o       = ext_resp_if.msg.addr;
  assign resp_data_o       = ext_resp_if.msg.data;

  assign init_done_o = init_done;

  mem_cfg_loader #(.init_words_p(init_words_p)) u_loader
  (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .cmd      (ldr_cmd_if.prod),
    .resp     (ldr_resp_if.cons),
    .done_o   (init_done)
  );

  mem_cmd_router u_router
  (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .init_done_i (init_done),
    .ldr_cmd     (ldr_cmd_if.cons),
    .ext_cmd     (ext_cmd_if.cons),
    .dram_cmd    (dram_cmd_if.prod),
    .mmio_cmd    (mmio_cmd_if.prod),
    .dram_resp   (dram_resp_if.cons),
    .mmio_resp   (mmio_resp_if.cons),
    .ldr_resp    (ldr_resp_if.prod),
    .ext_resp    (ext_resp_if.prod)
  );

  mem_dram_model
  #(
    .mem_words_p          (mem_words_p),
    .max_latency_p        (max_latency_p),
    .use_random_latency_p (use_random_latency_p)
  ) u_dram
  (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .cmd      (dram_cmd_if.cons),
    .resp     (dram_resp_if.prod)
  );

  mem_host_mmio u_mmio
  (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .cmd           (mmio_cmd_if.cons),
    .resp          (mmio_resp_if.prod),
    .finish_v_o    (finish_v_o),
    .finish_code_o (finish_code_o)
  );

endmodule

`default_nettype wire

// File: test/tb_mem_sys.sv
// Testbench for the memory subsystem
// Replays golden commands with random stalls and idle gaps, checks each response

`timescale 1ns/1ns
`default_nettype none

module tb_mem_sys;
  import mem_sys_pkg::*;

  localparam int init_words_lp  = 8;
  localparam int mem_words_lp   = 256;
  localparam int max_latency_lp = 6;
  localparam int use_random_lp  = 1;
  localparam int max_lines_lp   = 64;

  // Address map and init pattern as the subsystem defines them
  localparam logic [31:0] dram_base_lp  = 32'h8000_0000;
  localparam logic [31:0] count_addr_lp = 32'h0000_0008;
  localparam logic [31:0] init_seed_lp  = 32'hc0de_0000;

  logic        clk;
  logic        arst_n;
  logic        cmd_v;
  logic        cmd_ready;
  mem_op_e     cmd_op;
  logic [31:0] cmd_addr;
  logic [31:0] cmd_data;
  logic        resp_v;
  logic        resp_ready;
  mem_op_e     resp_op;
  logic [31:0] resp_addr;
  logic [31:0] resp_data;
  logic        init_done;
  logic        finish_v;
  logic [31:0] finish_code;

  // Four words per golden line: op, address, write data, expected data
  logic [31:0] golden_mem [4*max_lines_lp];
  int          num_lines;
  bit          golden_loaded;
  bit          init_seen;
  bit          finish_written;
  int          mmio_writes;

  mem_sys
  #(
    .init_words_p         (init_words_lp),
    .mem_words_p          (mem_words_lp),
    .max_latency_p        (max_latency_lp),
    .use_random_latency_p (use_random_lp)
  ) u_dut
  (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .cmd_v_i       (cmd_v),
    .cmd_ready_o   (cmd_ready),
    .cmd_op_i      (cmd_op),
    .cmd_addr_i    (cmd_addr),
    .cmd_data_i    (cmd_data),
    .resp_v_o      (resp_v),
    .resp_ready_i  (resp_ready),
    .resp_op_o     (resp_op),
    .resp_addr_o   (resp_addr),
    .resp_data_o   (resp_data),
    .init_done_o   (init_done),
    .finish_v_o    (finish_v),
    .finish_code_o (finish_code)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected)
    begin
      $display("[FAIL] %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
      $display("*** TEST FAILED ***");
      $fatal(1, "value mismatch");
    end
  endtask

  // One command from idle gap to taken response, sampled mid-cycle
  task automatic run_cmd(input logic op, input logic [31:0] addr,
                         input logic [31:0] wdata, input logic [31:0] exp_data);
    logic        accepted;
    logic        taken;
    logic        held;
    mem_op_e     held_op;
    logic [31:0] held_addr;
    logic [31:0] held_data;
    int          stalls;
    accepted = 1'b0;
    taken    = 1'b0;
    held     = 1'b0;
    stalls   = 0;
    repeat ($urandom % 3)
    begin
      @(negedge clk);
      cmd_v = 1'b0;
      #5;
      check_eq(32'(resp_v), 32'd0, "response with no command in flight");
    end
    @(negedge clk);
    cmd_v    = 1'b1;
    cmd_op   = mem_op_e'(op);
    cmd_addr = addr;
    cmd_data = wdata;
    #5;
    while (!accepted)
    begin
      check_eq(32'(resp_v), 32'd0, "response before the command was accepted");
      check_eq(32'(finish_v), 32'(finish_written), "finish_v_o");
      if (init_seen)
        check_eq(32'(init_done), 32'd1, "init_done_o dropped");
      else if (!init_done)
        check_eq(32'(cmd_ready), 32'd0, "cmd_ready_o before init_done_o");
      init_seen = init_seen | init_done;
      accepted  = cmd_ready;
      if (!accepted)
      begin
        @(negedge clk);
        #5;
      end
    end
    while (!taken)
    begin
      @(negedge clk);
      cmd_v      = 1'b0;
      resp_ready = (stalls < 2) ? (($urandom % 4) != 0) : 1'b1;
      #5;
      check_eq(32'(cmd_ready), 32'd0, "cmd_ready_o while a response is pending");
      if (held)
      begin
        // Stalled response must not move
        check_eq(32'(resp_v), 32'd1, "resp_v_o dropped under back-pressure");
        check_eq(32'(resp_op), 32'(held_op), "resp_op_o changed under back-pressure");
        check_eq(resp_addr, held_addr, "resp_addr_o changed under back-pressure");
        check_eq(resp_data, held_data, "resp_data_o changed under back-pressure");
      end
      if (resp_v && resp_ready)
      begin
        taken = 1'b1;
        check_eq(32'(resp_op), 32'(op), "resp_op_o");
        check_eq(resp_addr, addr, "resp_addr_o");
        check_eq(resp_data, exp_data, "resp_data_o");
      end
      else if (resp_v)
      begin
        held      = 1'b1;
        held_op   = resp_op;
        held_addr = resp_addr;
        held_data = resp_data;
        stalls++;
      end
    end
  endtask

  initial
  begin
    int unsigned seed_ret;
    logic        op;
    logic [31:0] addr;
    logic [31:0] exp_data;
    seed_ret       = $urandom(32'h5fa897c0);
    arst_n         = 1'b0;
    cmd_v          = 1'b0;
    cmd_op         = MEM_RD;
    cmd_addr       = '0;
    cmd_data       = '0;
    resp_ready     = 1'b0;
    init_seen      = 1'b0;
    finish_written = 1'b0;
    mmio_writes    = 0;
    // Unused entries stay far above any opcode
    for (int i = 0; i < 4*max_lines_lp; i++)
      golden_mem[i] = ~32'(i);
    $readmemh("test/mem_sys_golden.txt", golden_mem);
    num_lines = 0;
    while (num_lines < max_lines_lp && golden_mem[4*num_lines] <= 32'd1)
      num_lines++;
    golden_loaded = 1'b1;
    check_eq(32'(num_lines > 0), 32'd1, "commands found in golden file");

    repeat (16) @(negedge clk);
    check_eq(32'(init_done), 32'd0, "init_done_o in reset");
    check_eq(32'(cmd_ready), 32'd0, "cmd_ready_o in reset");
    check_eq(32'(resp_v), 32'd0, "resp_v_o in reset");
    check_eq(32'(finish_v), 32'd0, "finish_v_o in reset");
    arst_n = 1'b1;

    // Init pattern left by the loader
    for (int i = 0; i < init_words_lp; i++)
      run_cmd(1'b0, dram_base_lp + 32'(4*i), 32'd0, init_seed_lp ^ 32'(i));

    for (int l = 0; l < num_lines; l++)
    begin
      op       = golden_mem[4*l][0];
      addr     = golden_mem[4*l+1];
      exp_data = golden_mem[4*l+3];
      if (!op && addr == count_addr_lp)
        exp_data = 32'(mmio_writes);
      run_cmd(op, addr, golden_mem[4*l+2], exp_data);
      if (op && addr < dram_base_lp)
      begin
        mmio_writes++;
        finish_written = finish_written | (addr == 32'h0000_0000);
      end
    end

    @(negedge clk);
    #5;
    check_eq(32'(finish_v), 32'd1, "finish_v_o after finish write");
    check_eq(finish_code, golden_mem[4*(num_lines-1)+2], "finish_code_o");
    $display("*** TEST PASSED ***");
    $finish;
  end

  initial
  begin
    wait (golden_loaded);
    repeat ((16 + init_words_lp + num_lines) * (max_latency_lp + 4)) @(posedge clk);
    $display("Timeout: the run did not complete within the allowed clock cycles");
    $display("*** TEST FAILED ***");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: test/mem_sys_golden.txt
// Columns: op (0 read, 1 write), address, write data, expected response data
// Count register reads are also checked against the testbench's own MMIO write count
1 80000040 11112222 11112222
0 80000040 00000000 11112222
1 800000fc a5a55a5a a5a55a5a
1 80000100 0badf00d 0badf00d
0 800000fc 00000000 a5a55a5a
0 80000100 00000000 0badf00d
1 80000444 cafe0001 cafe0001
0 80000044 00000000 cafe0001
0 80000444 00000000 cafe0001
1 80000004 12345678 12345678
0 80000004 00000000 12345678
0 80000008 00000000 c0de0002
0 00000008 00000000 00000000
1 00000004 deadbeef deadbeef
0 00000004 00000000 deadbeef
0 00000008 00000000 00000001
1 00000004 5555aaaa 5555aaaa
0 00000008 00000000 00000002
0 00000004 00000000 5555aaaa
0 00000010 00000000 00000000
0 7ffffffc 00000000 00000000
0 80000000 00000000 c0de0000
1 00000000 0000002a 0000002a

// File: mem_sys.f
common/mem_sys_pkg.sv
common/mem_msg_if.sv
logic/mem_cfg_loader.sv
logic/mem_cmd_router.sv
mem/mem_dram_model.sv
mem/mem_host_mmio.sv
logic/mem_sys.sv
test/tb_mem_sys.sv

// File: Makefile
TOP := tb_mem_sys

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f mem_sys.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
